// ==== source/lsu_pkg.sv ====
// Core-side load/store definitions, imported by every block of the load/store unit
`default_nettype none

package lsu_pkg;

  ////////////////////////////////////////////////////////////
  // Access size
  ////////////////////////////////////////////////////////////

  // Encoding follows the funct3 low bits of RISC-V loads and stores
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'b00,
    SIZE_HALF = 2'b01,
    SIZE_WORD = 2'b10
  } lsu_size_e;

  ////////////////////////////////////////////////////////////
  // Address and data
  ////////////////////////////////////////////////////////////

  // Byte address, not necessarily aligned
  typedef logic [31:0] lsu_addr_t;

  // One data word as seen by the core and the bus
  typedef logic [31:0] lsu_data_t;

  // Bytes per word, step between the halves of a split access
  localparam int unsigned WORD_BYTES = 4;

endpackage : lsu_pkg

`default_nettype wire

// ==== source/bus_pkg.sv ====
// Bus-side definitions for the data bus: byte lanes and transfer tracking
`default_nettype none

package bus_pkg;

  // One enable per byte lane of the data bus
  typedef logic [3:0] bus_be_t;

  // Byte offset inside a word, selects the lane of the first byte
  typedef logic [1:0] lane_ofs_t;

  // Transfers that may be granted but not yet answered
  localparam int unsigned MAX_OUTSTANDING = 2;

  // Outstanding count, wide enough to hold MAX_OUTSTANDING
  typedef logic [1:0] cnt_t;

endpackage : bus_pkg

`default_nettype wire

// ==== source/lsu_req_if.sv ====
// Aligned bus request from the request generator to the bus controller and read aligner
`timescale 1ns/1ns
`default_nettype none

interface lsu_req_if import lsu_pkg::*, bus_pkg::*; ();

  // Handshake, taken when both are high
  logic      req_valid;
  logic      req_ready;

  // Bus-ready transfer, already word aligned for a second half
  lsu_addr_t addr;
  logic      we;
  bus_be_t   be;
  lsu_data_t wdata;

  // Load control, kept per transfer by the aligner
  lsu_size_e size;
  logic      sext;
  lane_ofs_t ofs;
  // Low only for the first half of a split access
  logic      last;

  modport gen (
    output req_valid, addr, we, be, wdata, size, sext, ofs, last,
    input  req_ready
  );

  modport ctrl (
    input  req_valid, addr, we, be, wdata, last,
    output req_ready
  );

  modport mon (
    input req_valid, req_ready, addr, we, be, wdata, size, sext, ofs, last
  );

endinterface : lsu_req_if

`default_nettype wire

// ==== source/lsu_req_gen.sv ====
// EX side of the load/store unit: address, byte enables, write data and split tracking
`timescale 1ns/1ns
`default_nettype none

module lsu_req_gen import lsu_pkg::*, bus_pkg::*; (
  input  wire        clk,
  input  wire        rst_n,
  input  logic       valid_i,
  input  lsu_addr_t  op_a_i,
  input  lsu_addr_t  op_b_i,
  input  logic       we_i,
  input  lsu_size_e  size_i,
  input  logic       sext_i,
  input  lsu_data_t  wdata_i,
  lsu_req_if.gen     req
);

  lsu_addr_t addr;
  lane_ofs_t ofs;
  logic      split_first;
  // Second half of a split access is on the bus
  logic      split_q;
  bus_be_t   be;
  lsu_data_t wdata_rot;

  // Effective address from base and offset operands
  assign addr = op_a_i + op_b_i;
  assign ofs  = addr[1:0];

  // First half of an access that crosses a word boundary
  always_comb begin
    split_first = 1'b0;
    if (valid_i && !split_q) begin
      if (size_i == SIZE_WORD && ofs != 2'b00) begin
        split_first = 1'b1;
      end
      if (size_i == SIZE_HALF && ofs == 2'b11) begin
        split_first = 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Byte enables
  ////////////////////////////////////////////////////////////

  always_comb begin
    be = 4'b0000;
    unique case (size_i)
      SIZE_BYTE: begin
        be = 4'b0001 << ofs;
      end
      SIZE_HALF: begin
        if (split_q) begin
          // Upper byte spills into lane 0 of the next word
          be = 4'b0001;
        end else begin
          case (ofs)
            2'b00: be = 4'b0011;
            2'b01: be = 4'b0110;
            default: be = 4'b1100 << ofs[0];
          endcase
        end
      end
      default: begin
        if (split_q) begin
          // Remaining low lanes, ofs of them
          case (ofs)
            2'b01: be = 4'b0001;
            2'b10: be = 4'b0011;
            2'b11: be = 4'b0111;
            default: be = 4'b0000;
          endcase
        end else begin
          be = 4'b1111 << ofs;
        end
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Write data
  ////////////////////////////////////////////////////////////

  // Rotate left by the byte offset, both halves use the same lanes
  always_comb begin
    case (ofs)
      2'b01:   wdata_rot = {wdata_i[23:0], wdata_i[31:24]};
      2'b10:   wdata_rot = {wdata_i[15:0], wdata_i[31:16]};
      2'b11:   wdata_rot = {wdata_i[7:0],  wdata_i[31:8]};
      default: wdata_rot = wdata_i;
    endcase
  end

  // Split phase, dropped whenever EX has nothing valid
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      split_q <= 1'b0;
    end else if (!valid_i) begin
      split_q <= 1'b0;
    end else if (req.req_valid && req.req_ready) begin
      // Set after the first half, cleared after the second
      split_q <= split_first;
    end
  end

  // Drive the request
  assign req.req_valid = valid_i;
  // Second half goes to the next word-aligned address
  assign req.addr  = split_q ? ({addr[31:2], 2'b00} + lsu_addr_t'(WORD_BYTES)) : addr;
  assign req.we    = we_i;
  assign req.be    = be;
  assign req.wdata = wdata_rot;
  assign req.size  = size_i;
  assign req.sext  = sext_i;
  assign req.ofs   = ofs;
  assign req.last  = !split_first;

endmodule : lsu_req_gen

`default_nettype wire

// ==== source/lsu_bus_ctrl.sv ====
// Data bus master: request/grant handshake, outstanding-transfer count and EX handshake
`timescale 1ns/1ns
`default_nettype none

module lsu_bus_ctrl import lsu_pkg::*, bus_pkg::*; (
  input  wire        clk,
  input  wire        rst_n,
  lsu_req_if.ctrl    req,
  output logic       data_req_o,
  input  logic       data_gnt_i,
  output lsu_addr_t  data_addr_o,
  output logic       data_we_o,
  output bus_be_t    data_be_o,
  output lsu_data_t  data_wdata_o,
  input  logic       data_rvalid_i,
  output logic       ready_o,
  output logic       busy_o
);

  cnt_t cnt_q;
  cnt_t cnt_d;
  logic room;
  logic count_up;
  logic count_down;

  // Room for one more transfer in flight
  assign room = (cnt_q < cnt_t'(MAX_OUTSTANDING));

  ////////////////////////////////////////////////////////////
  // Request phase
  ////////////////////////////////////////////////////////////

  // Request masked at the limit, grant forwarded as is
  assign data_req_o    = req.req_valid && room;
  assign req.req_ready = data_gnt_i && room;

  assign data_addr_o  = req.addr;
  assign data_we_o    = req.we;
  assign data_be_o    = req.be;
  assign data_wdata_o = req.wdata;

  // EX may move on once its last transfer is granted
  assign ready_o = req.req_valid && req.req_ready && req.last;

  ////////////////////////////////////////////////////////////
  // Outstanding transfers
  ////////////////////////////////////////////////////////////

  assign count_up   = req.req_valid && req.req_ready;
  // Responses only follow grants, no underflow
  assign count_down = data_rvalid_i;

  always_comb begin
    case ({count_up, count_down})
      2'b10:   cnt_d = cnt_q + cnt_t'(1);
      2'b01:   cnt_d = cnt_q - cnt_t'(1);
      // Grant and response together keep the count
      default: cnt_d = cnt_q;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  // Busy while anything is in flight or waiting for a grant
  assign busy_o = (cnt_q != '0) || req.req_valid;

endmodule : lsu_bus_ctrl

`default_nettype wire

// ==== source/lsu_rdata_align.sv ====
// WB side of the load/store unit: per-transfer control FIFO, read realignment and extension
`timescale 1ns/1ns
`default_nettype none

module lsu_rdata_align import lsu_pkg::*, bus_pkg::*; (
  input  wire        clk,
  input  wire        rst_n,
  lsu_req_if.mon     req,
  input  logic       data_rvalid_i,
  input  lsu_data_t  data_rdata_i,
  input  logic       data_err_i,
  output logic       result_valid_o,
  output lsu_data_t  result_rdata_o,
  output logic       result_err_o
);

  // Control FIFO storage, one entry per granted transfer
  lsu_size_e size_mem [MAX_OUTSTANDING];
  logic      sext_mem [MAX_OUTSTANDING];
  logic      we_mem   [MAX_OUTSTANDING];
  lane_ofs_t ofs_mem  [MAX_OUTSTANDING];
  logic      last_mem [MAX_OUTSTANDING];

  logic      wr_ptr_q;
  logic      rd_ptr_q;
  logic      push;
  logic      pop;

  // Head entry, matches the response on the bus
  lsu_size_e head_size;
  logic      head_sext;
  logic      head_we;
  lane_ofs_t head_ofs;
  logic      head_last;
  logic      head_split;

  // First half of a split access
  lsu_data_t rdata_q;
  logic      err_q;

  logic [63:0] rdata_pair;
  logic [63:0] rdata_shift;

  assign push = req.req_valid && req.req_ready;
  // Responses return in request order
  assign pop  = data_rvalid_i;

  ////////////////////////////////////////////////////////////
  // Control FIFO
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (push) begin
      size_mem[wr_ptr_q] <= req.size;
      sext_mem[wr_ptr_q] <= req.sext;
      we_mem[wr_ptr_q]   <= req.we;
      ofs_mem[wr_ptr_q]  <= req.ofs;
      last_mem[wr_ptr_q] <= req.last;
    end
  end

  // Depth is bounded by the bus controller count
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr_q <= !wr_ptr_q;
      end
      if (pop) begin
        rd_ptr_q <= !rd_ptr_q;
      end
    end
  end

  assign head_size = size_mem[rd_ptr_q];
  assign head_sext = sext_mem[rd_ptr_q];
  assign head_we   = we_mem[rd_ptr_q];
  assign head_ofs  = ofs_mem[rd_ptr_q];
  assign head_last = last_mem[rd_ptr_q];

  // Same split rule as on the request side
  assign head_split = ((head_size == SIZE_WORD) && (head_ofs != 2'b00)) ||
                      ((head_size == SIZE_HALF) && (head_ofs == 2'b11));

  ////////////////////////////////////////////////////////////
  // First half storage
  ////////////////////////////////////////////////////////////

  // Raw load word only, stores need no data
  always_ff @(posedge clk) begin
    if (pop && !head_last && !head_we) begin
      rdata_q <= data_rdata_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      err_q <= 1'b0;
    end else if (pop && !head_last) begin
      err_q <= data_err_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // Realign and extend
  ////////////////////////////////////////////////////////////

  // Low word from the first half when split, else the same word twice
  assign rdata_pair  = head_split ? {data_rdata_i, rdata_q} : {data_rdata_i, data_rdata_i};
  assign rdata_shift = rdata_pair >> {head_ofs, 3'b000};

  always_comb begin
    unique case (head_size)
      SIZE_BYTE: result_rdata_o = {{24{head_sext && rdata_shift[7]}}, rdata_shift[7:0]};
      SIZE_HALF: result_rdata_o = {{16{head_sext && rdata_shift[15]}}, rdata_shift[15:0]};
      default:   result_rdata_o = rdata_shift[31:0];
    endcase
  end

  // One result per access, on its last response
  assign result_valid_o = pop && head_last;
  // Error of either half of the access
  assign result_err_o   = data_err_i || (head_split && err_q);

endmodule : lsu_rdata_align

`default_nettype wire

// ==== source/lsu_core.sv ====
// Top level of the load/store unit, EX inputs in and data bus plus WB result out
`timescale 1ns/1ns
`default_nettype none

module lsu_core import lsu_pkg::*, bus_pkg::*; (
  input  wire        clk,
  input  wire        rst_n,

  // EX side
  input  logic       valid_i,
  output logic       ready_o,
  input  lsu_addr_t  op_a_i,
  input  lsu_addr_t  op_b_i,
  input  logic       we_i,
  input  lsu_size_e  size_i,
  input  logic       sext_i,
  input  lsu_data_t  wdata_i,

  // Data bus
  output logic       data_req_o,
  input  logic       data_gnt_i,
  output lsu_addr_t  data_addr_o,
  output logic       data_we_o,
  output bus_be_t    data_be_o,
  output lsu_data_t  data_wdata_o,
  input  logic       data_rvalid_i,
  input  lsu_data_t  data_rdata_i,
  input  logic       data_err_i,

  // WB side
  output logic       result_valid_o,
  output lsu_data_t  result_rdata_o,
  output logic       result_err_o,
  output logic       busy_o
);

  // Aligned request shared by all three blocks
  lsu_req_if req_if ();

  lsu_req_gen i_req_gen (
    .clk     (clk),
    .rst_n   (rst_n),
    .valid_i (valid_i),
    .op_a_i  (op_a_i),
    .op_b_i  (op_b_i),
    .we_i    (we_i),
    .size_i  (size_i),
    .sext_i  (sext_i),
    .wdata_i (wdata_i),
    .req     (req_if.gen)
  );

  lsu_bus_ctrl i_bus_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .req           (req_if.ctrl),
    .data_req_o    (data_req_o),
    .data_gnt_i    (data_gnt_i),
    .data_addr_o   (data_addr_o),
    .data_we_o     (data_we_o),
    .data_be_o     (data_be_o),
    .data_wdata_o  (data_wdata_o),
    .data_rvalid_i (data_rvalid_i),
    .ready_o       (ready_o),
    .busy_o        (busy_o)
  );

  lsu_rdata_align i_rdata_align (
    .clk            (clk),
    .rst_n          (rst_n),
    .req            (req_if.mon),
    .data_rvalid_i  (data_rvalid_i),
    .data_rdata_i   (data_rdata_i),
    .data_err_i     (data_err_i),
    .result_valid_o (result_valid_o),
    .result_rdata_o (result_rdata_o),
    .result_err_o   (result_err_o)
  );

endmodule : lsu_core

`default_nettype wire

// ==== verif/tb_clk_gen.sv ====
// Clock and reset source for the load/store unit testbench, instantiated once by the top
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  localparam int HALF_PERIOD_NS = 20;
  localparam int RESET_CYCLES   = 4;

  // Free running 40 ns clock
  initial begin
    clk_o = 1'b0;
    forever #HALF_PERIOD_NS clk_o = ~clk_o;
  end

  // Reset released shortly after an edge, like any other input
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #5;
    rst_n_o = 1'b1;
  end

endmodule : tb_clk_gen

`default_nettype wire

// ==== verif/tb_lsu_core.sv ====
// Random load/store testbench for the load/store unit with a byte-array memory responder
`timescale 1ns/1ns
`default_nettype none

module tb_lsu_core import lsu_pkg::*; ();

  localparam int NUM_ACCESSES = 400;
  localparam int MEM_BYTES    = 32;

  // Expected bus transfer for each grant
  typedef struct packed {
    logic [31:0] addr;
    logic [3:0]  be;
    logic        we;
    logic [31:0] wdata;
    logic        last;
  } xfer_t;

  // Pending bus response
  typedef struct packed {
    logic [31:0] data;
    logic        last;
    logic [31:0] due;
  } resp_t;

  // Expected WB result of one access
  typedef struct packed {
    logic        we;
    logic [31:0] data;
  } result_t;

  logic clk;
  logic rst_n;
  logic valid_i, ready_o, we_i, sext_i;
  lsu_addr_t op_a_i, op_b_i;
  lsu_size_e size_i;
  lsu_data_t wdata_i;
  logic data_req_o, data_gnt_i, data_we_o, data_rvalid_i, data_err_i;
  logic [3:0] data_be_o;
  lsu_addr_t data_addr_o;
  lsu_data_t data_wdata_o, data_rdata_i;
  logic result_valid_o, result_err_o, busy_o;
  lsu_data_t result_rdata_o;

  // Bus memory is written through the DUT and reference memory by the model
  logic [7:0] bus_mem [MEM_BYTES];
  logic [7:0] ref_mem [MEM_BYTES];
  xfer_t      xfer_q [$];
  resp_t      resp_q [$];
  result_t    res_q [$];

  logic [31:0] rng_state = 32'h113a_2a69;
  logic [31:0] cycle = '0;
  int          errors = 0;
  int          out_cnt = 0;
  int          granted = 0;
  int          exp_xfers = 0;
  int          results = 0;
  logic [1:0]  gnt_wait = '0;
  logic        err_acc = 1'b0;
  // Responder outputs for the next cycle
  logic        gnt_nxt, rvalid_nxt, err_nxt, last_nxt, cur_last;
  logic [31:0] rdata_nxt;

  tb_clk_gen i_clk_gen (.clk_o(clk), .rst_n_o(rst_n));

  lsu_core i_dut (.*);

  // LCG with the Numerical Recipes constants
  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus and reference model
  ////////////////////////////////////////////////////////////

  task automatic launch_access();
    logic [31:0] r;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] value;
    logic [63:0] dbl;
    lsu_size_e   size;
    int          k;
    int          nbytes;
    xfer_t       first;
    xfer_t       second;
    r = next_rand();
    size = (r[31:30] == 2'b00) ? SIZE_BYTE : ((r[31:30] == 2'b01) ? SIZE_HALF : SIZE_WORD);
    op_a_i = next_rand();
    op_b_i = next_rand();
    wdata = next_rand();
    addr = op_a_i + op_b_i;
    k = int'(addr[1:0]);
    nbytes = (size == SIZE_BYTE) ? 1 : ((size == SIZE_HALF) ? 2 : 4);
    // Write data rotated left by the byte offset
    dbl = {wdata, wdata};
    first.addr  = addr;
    first.we    = r[29];
    first.wdata = dbl[63 - 8 * k -: 32];
    first.last  = (k + nbytes <= 4);
    second      = first;
    second.addr = {addr[31:2], 2'b00} + 32'd4;
    second.last = 1'b1;
    for (int j = 0; j < 4; j++) begin
      first.be[j]  = (j >= k) && (j < k + nbytes);
      second.be[j] = (j + 4 < k + nbytes);
    end
    xfer_q.push_back(first);
    exp_xfers++;
    if (!first.last) begin
      xfer_q.push_back(second);
      exp_xfers++;
    end
    // Bytes of the access in address order
    value = '0;
    for (int i = 0; i < nbytes; i++) begin
      if (r[29]) begin
        ref_mem[5'(addr + i)] = wdata[8 * i +: 8];
      end else begin
        value[8 * i +: 8] = ref_mem[5'(addr + i)];
      end
    end
    if (r[28] && size == SIZE_BYTE && value[7]) begin
      value[31:8] = '1;
    end
    if (r[28] && size == SIZE_HALF && value[15]) begin
      value[31:16] = '1;
    end
    res_q.push_back({r[29], value});
    valid_i = 1'b1;
    we_i    = r[29];
    size_i  = size;
    sext_i  = r[28];
    wdata_i = wdata;
  endtask

  ////////////////////////////////////////////////////////////
  // Memory responder and bus checks
  ////////////////////////////////////////////////////////////

  // Runs at the falling edge where all DUT outputs are settled
  task automatic bus_cycle();
    logic [31:0] r;
    logic [31:0] base;
    logic [31:0] rd;
    logic [31:0] mask;
    xfer_t       xf;
    resp_t       resp;
    result_t     res;
    r = next_rand();
    cycle = cycle + 1;
    // Request follows EX valid unless two transfers are in flight
    check_val("data_req_o", data_req_o, valid_i && (out_cnt < 2));
    check_val("busy_o", busy_o, valid_i || (out_cnt != 0));
    if (result_valid_o) begin
      results++;
    end
    // Response on the bus this cycle
    if (data_rvalid_i) begin
      out_cnt--;
      check_val("result_valid_o", result_valid_o, cur_last);
      if (cur_last) begin
        res = res_q.pop_front();
        check_val("result_err_o", result_err_o, err_acc | data_err_i);
        if (!res.we) begin
          check_val("result_rdata_o", result_rdata_o, res.data);
        end
      end
      err_acc = cur_last ? 1'b0 : (err_acc | data_err_i);
    end else begin
      check_val("result_valid_o", result_valid_o, 1'b0);
    end
    // Grant taken at the coming edge
    if (data_req_o && data_gnt_i) begin
      granted++;
      if (xfer_q.size() == 0) begin
        errors++;
        $display("At %0t ns a bus request was granted that no access asked for", $time);
      end else begin
        xf = xfer_q.pop_front();
        check_val("data_addr_o", data_addr_o, xf.addr);
        check_val("data_be_o", data_be_o, xf.be);
        check_val("data_we_o", data_we_o, xf.we);
        check_val("ready_o", ready_o, xf.last);
        base = {data_addr_o[31:2], 2'b00};
        for (int j = 0; j < 4; j++) begin
          mask[8 * j +: 8] = {8{xf.be[j]}};
          if (data_we_o && data_be_o[j]) begin
            bus_mem[5'(base + j)] = data_wdata_o[8 * j +: 8];
          end
          rd[8 * j +: 8] = bus_mem[5'(base + j)];
        end
        if (xf.we) begin
          check_val("data_wdata_o", data_wdata_o & mask, xf.wdata & mask);
        end
        resp_q.push_back({rd, xf.last, cycle + 32'd1 + r[31:30]});
        out_cnt++;
      end
      gnt_wait = r[29:28];
    end else begin
      check_val("ready_o", ready_o, 1'b0);
      if (gnt_wait != 0) begin
        gnt_wait--;
      end
    end
    gnt_nxt = (gnt_wait == 0);
    // At most one response per cycle and in order
    rvalid_nxt = 1'b0;
    err_nxt    = 1'b0;
    rdata_nxt  = '0;
    if (resp_q.size() != 0 && resp_q[0].due <= cycle + 1) begin
      resp = resp_q.pop_front();
      rvalid_nxt = 1'b1;
      rdata_nxt  = resp.data;
      last_nxt   = resp.last;
      err_nxt    = (r[27:25] == 3'b000);
    end
  endtask

  always begin
    @(negedge clk);
    if (rst_n) begin
      bus_cycle();
    end
    @(posedge clk);
    #5;
    data_gnt_i    = gnt_nxt;
    data_rvalid_i = rvalid_nxt;
    data_rdata_i  = rdata_nxt;
    data_err_i    = err_nxt;
    cur_last      = last_nxt;
  end

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] r;
    {valid_i, we_i, sext_i, data_gnt_i, data_rvalid_i, data_err_i} = '0;
    {gnt_nxt, rvalid_nxt, err_nxt, last_nxt, cur_last} = '0;
    op_a_i = '0;
    op_b_i = '0;
    wdata_i = '0;
    size_i = SIZE_BYTE;
    data_rdata_i = '0;
    rdata_nxt = '0;
    for (int i = 0; i < MEM_BYTES; i++) begin
      bus_mem[i] = 8'(i * 29 + 90);
      ref_mem[i] = 8'(i * 29 + 90);
    end
    wait (rst_n);
    @(negedge clk);
    check_val("busy_o", busy_o, 1'b0);
    check_val("data_req_o", data_req_o, 1'b0);
    check_val("ready_o", ready_o, 1'b0);
    for (int n = 0; n < NUM_ACCESSES; n++) begin
      @(posedge clk);
      #5;
      r = next_rand();
      // Idle cycle now and then
      if (r[31:30] == 2'b00) begin
        valid_i = 1'b0;
        @(posedge clk);
        #5;
      end
      launch_access();
      do @(negedge clk); while (!ready_o);
    end
    @(posedge clk);
    #5;
    valid_i = 1'b0;
    while (out_cnt != 0) @(posedge clk);
    @(negedge clk);
    check_val("busy_o", busy_o, 1'b0);
    check_val("granted transfers", granted, exp_xfers);
    check_val("result pulses", results, NUM_ACCESSES);
    $display("Run done: %0d accesses, %0d transfers, %0d errors", results, granted, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // Watchdog allows 20 cycles per access
  initial begin
    repeat (NUM_ACCESSES * 20) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", NUM_ACCESSES * 20);
    $display("TB FAILED");
    $finish;
  end

endmodule : tb_lsu_core

`default_nettype wire

// ==== lsu_core.f ====
source/lsu_pkg.sv
source/bus_pkg.sv
source/lsu_req_if.sv
source/lsu_req_gen.sv
source/lsu_bus_ctrl.sv
source/lsu_rdata_align.sv
source/lsu_core.sv
verif/tb_clk_gen.sv
verif/tb_lsu_core.sv
